/* source/mipsDefs.svh */
`ifndef MIPS_DEFS_SVH
`define MIPS_DEFS_SVH

// machine word width in bits
`define MIPS_WORD_WIDTH 32

// architectural register count
// register 31 doubles as the link register for jal
`define MIPS_REG_COUNT 32

// instruction memory depth in words
`define MIPS_IMEM_DEPTH 256

// data memory depth in words
`define MIPS_DMEM_DEPTH 256

// link register index
`define MIPS_RA_INDEX 31

// immediate field width
`define MIPS_IMM_WIDTH 16

`endif

/* source/mipsPkg.sv */
`default_nettype none

`include "mipsDefs.svh"

package mipsPkg;

    // one machine word
    typedef logic [`MIPS_WORD_WIDTH-1:0] wordT;

    // primary opcodes, instr[31:26]
    // anything not listed decodes as a no-op
    typedef enum logic [5:0] {
        opLw    = 6'd8,
        opSw    = 6'd9,
        opJ     = 6'd10,
        opJal   = 6'd11,
        opBne   = 6'd12,
        opRType = 6'd13
    } opcodeT;

    // alu operations, also the low funct bits of an r-type
    typedef enum logic [2:0] {
        aluAdd  = 3'd0,
        aluSub  = 3'd1,
        aluXor  = 3'd2,
        aluSlt  = 3'd3,
        aluAnd  = 3'd4,
        aluNand = 3'd5,
        aluNor  = 3'd6,
        aluOr   = 3'd7
    } aluCommandT;

    // where the write-back register address comes from
    typedef enum logic [1:0] {regDstRt, regDstRd, regDstRa} regDstT;

    // where the write-back data comes from
    typedef enum logic [1:0] {srcAlu, srcDataMem, srcPcPlus4} regDataSrcT;

endpackage

`default_nettype wire

/* source/controlUnitLUT.sv */
`timescale 1ns/10ps
`default_nettype none

// opcode to datapath control levels
module controlUnitLUT (
    input  mipsPkg::opcodeT     opcode,
    input  logic [2:0]          funct,
    output logic                wrEnReg,
    output logic                wrEnDm,
    output mipsPkg::regDstT     regDst,
    output logic                aluSrcImm,
    output mipsPkg::aluCommandT aluCommand,
    output mipsPkg::regDataSrcT regDataSrc,
    output logic                jump,
    output logic                branch
);

    always_comb begin
        // no-op row, overridden per opcode below
        wrEnReg    = 1'b0;
        wrEnDm     = 1'b0;
        regDst     = mipsPkg::regDstRt;
        aluSrcImm  = 1'b0;
        aluCommand = mipsPkg::aluAdd;
        regDataSrc = mipsPkg::srcAlu;
        jump       = 1'b0;
        branch     = 1'b0;
        case (opcode)
            mipsPkg::opLw: begin
                // rt gets mem[rs + imm]
                wrEnReg    = 1'b1;
                regDst     = mipsPkg::regDstRt;
                aluSrcImm  = 1'b1;
                aluCommand = mipsPkg::aluAdd;
                regDataSrc = mipsPkg::srcDataMem;
            end
            mipsPkg::opSw: begin
                // address from rs + imm, data from rt
                wrEnDm     = 1'b1;
                aluSrcImm  = 1'b1;
                aluCommand = mipsPkg::aluAdd;
            end
            mipsPkg::opJ: begin
                jump = 1'b1;
            end
            mipsPkg::opJal: begin
                // return address lands in r31
                jump       = 1'b1;
                wrEnReg    = 1'b1;
                regDst     = mipsPkg::regDstRa;
                regDataSrc = mipsPkg::srcPcPlus4;
            end
            mipsPkg::opBne: begin
                // nonzero difference means taken
                aluCommand = mipsPkg::aluSub;
                branch     = 1'b1;
            end
            mipsPkg::opRType: begin
                wrEnReg    = 1'b1;
                regDst     = mipsPkg::regDstRd;
                // funct low bits are the alu command directly
                aluCommand = mipsPkg::aluCommandT'(funct);
                regDataSrc = mipsPkg::srcAlu;
            end
            default: begin
                // unknown opcode, keep the no-op row
                wrEnReg = 1'b0;
                wrEnDm  = 1'b0;
            end
        endcase
    end

    // no row in the table may write both register file and data memory
    always_comb begin
        noDoubleWrite: assert (!(wrEnReg && wrEnDm))
            else $error("controlUnitLUT: register and memory write both enabled");
    end

endmodule

`default_nettype wire

/* source/alu.sv */
`timescale 1ns/10ps
`default_nettype none

// eight-operation alu
module alu (
    input  mipsPkg::wordT       a,
    input  mipsPkg::wordT       b,
    input  mipsPkg::aluCommandT command,
    output mipsPkg::wordT       result,
    output logic                zero
);

    // signed compare for slt
    logic lessThan;

    assign lessThan = $signed(a) < $signed(b);

    always_comb begin
        case (command)
            mipsPkg::aluAdd:  result = a + b;
            mipsPkg::aluSub:  result = a - b;
            mipsPkg::aluXor:  result = a ^ b;
            // 1 or 0, zero extended
            mipsPkg::aluSlt:  result = mipsPkg::wordT'(lessThan);
            mipsPkg::aluAnd:  result = a & b;
            mipsPkg::aluNand: result = ~(a & b);
            mipsPkg::aluNor:  result = ~(a | b);
            mipsPkg::aluOr:   result = a | b;
            default:          result = a + b;
        endcase
    end

    // bne uses this after a subtract
    assign zero = (result == '0);

endmodule

`default_nettype wire

/* source/registerFile.sv */
`timescale 1ns/10ps
`default_nettype none

`include "mipsDefs.svh"

// two read ports, one write port, r0 hardwired to zero
module registerFile (
    input  logic          clk,
    input  logic          reset,
    input  logic [4:0]    rdAddrA,
    input  logic [4:0]    rdAddrB,
    output mipsPkg::wordT rdDataA,
    output mipsPkg::wordT rdDataB,
    input  logic          wrEn,
    input  logic [4:0]    wrAddr,
    input  mipsPkg::wordT wrData
);

    mipsPkg::wordT regs [`MIPS_REG_COUNT];

    // sync clear of every register, r0 never written afterwards
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `MIPS_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn && (wrAddr != '0)) begin
            regs[wrAddr] <= wrData;
        end
    end

    // combinational reads
    // same-cycle write is not forwarded, old value comes out
    assign rdDataA = (rdAddrA == '0) ? '0 : regs[rdAddrA];
    assign rdDataB = (rdAddrB == '0) ? '0 : regs[rdAddrB];

    // write address must be fully driven whenever a write is requested
    wrAddrKnown: assert property (
        @(posedge clk) disable iff (reset) wrEn |-> !$isunknown(wrAddr)
    ) else $error("registerFile: unknown write address");

endmodule

`default_nettype wire

/* source/wordMemory.sv */
`timescale 1ns/10ps
`default_nettype none

// word-addressed ram, async read, sync write
// serves as both imem and dmem
module wordMemory #(
    parameter int depth = 256
) (
    input  logic                       clk,
    input  logic [$clog2(depth)-1:0]   rdAddr,
    output mipsPkg::wordT              rdData,
    input  logic                       wrEn,
    input  logic [$clog2(depth)-1:0]   wrAddr,
    input  mipsPkg::wordT              wrData
);

    mipsPkg::wordT mem [depth];

    // contents survive reset so a preloaded program stays put
    always_ff @(posedge clk) begin
        if (wrEn) begin
            mem[wrAddr] <= wrData;
        end
    end

    assign rdData = mem[rdAddr];

    // only matters for depths that are not a power of two
    wrAddrInRange: assert property (
        @(posedge clk) wrEn |-> (wrAddr < depth)
    ) else $error("wordMemory: write address %0d beyond depth %0d", wrAddr, depth);

endmodule

`default_nettype wire

/* source/singleCycleCpu.sv */
`timescale 1ns/10ps
`default_nettype none

`include "mipsDefs.svh"

// single-cycle core with a load port for imem and dmem
module singleCycleCpu (
    input  logic          clk,
    input  logic          reset,
    input  logic          loadEn,
    input  logic          loadSel,
    input  logic [7:0]    loadAddr,
    input  mipsPkg::wordT loadData,
    output mipsPkg::wordT pc,
    output logic          regWrEn,
    output logic [4:0]    regWrAddr,
    output mipsPkg::wordT regWrData,
    output logic          memWrEn,
    output mipsPkg::wordT memWrAddr,
    output mipsPkg::wordT memWrData
);

    localparam int imemAddrWidth = $clog2(`MIPS_IMEM_DEPTH);
    localparam int dmemAddrWidth = $clog2(`MIPS_DMEM_DEPTH);

    // fetch
    mipsPkg::wordT instr;
    mipsPkg::wordT pcPlus4;
    mipsPkg::wordT nextPc;
    mipsPkg::wordT immExt;
    mipsPkg::wordT jumpTarget;
    mipsPkg::wordT branchTarget;

    // decode levels
    logic                ctrlWrEnReg;
    logic                ctrlWrEnDm;
    mipsPkg::regDstT     regDst;
    logic                aluSrcImm;
    mipsPkg::aluCommandT aluCommand;
    mipsPkg::regDataSrcT regDataSrc;
    logic                jump;
    logic                branch;

    // execute
    mipsPkg::wordT rdDataA;
    mipsPkg::wordT rdDataB;
    mipsPkg::wordT aluB;
    mipsPkg::wordT aluResult;
    logic          aluZero;
    mipsPkg::wordT dmemRdData;

    // dmem write port, shared by load port and core
    logic                     dmemWrEn;
    logic [dmemAddrWidth-1:0] dmemWrAddr;
    mipsPkg::wordT            dmemWrData;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= '0;
        end else begin
            pc <= nextPc;
        end
    end

    // imem written only by the load port during reset
    wordMemory #(.depth(`MIPS_IMEM_DEPTH)) imem (
        .clk    (clk),
        .rdAddr (pc[imemAddrWidth+1:2]),
        .rdData (instr),
        .wrEn   (reset && loadEn && !loadSel),
        .wrAddr (loadAddr[imemAddrWidth-1:0]),
        .wrData (loadData)
    );

    controlUnitLUT controlUnitLUT_inst (
        .opcode     (mipsPkg::opcodeT'(instr[31:26])),
        .funct      (instr[2:0]),
        .wrEnReg    (ctrlWrEnReg),
        .wrEnDm     (ctrlWrEnDm),
        .regDst     (regDst),
        .aluSrcImm  (aluSrcImm),
        .aluCommand (aluCommand),
        .regDataSrc (regDataSrc),
        .jump       (jump),
        .branch     (branch)
    );

    registerFile registerFile_inst (
        .clk     (clk),
        .reset   (reset),
        .rdAddrA (instr[25:21]),
        .rdAddrB (instr[20:16]),
        .rdDataA (rdDataA),
        .rdDataB (rdDataB),
        .wrEn    (regWrEn),
        .wrAddr  (regWrAddr),
        .wrData  (regWrData)
    );

    // sign-extended 16-bit immediate
    assign immExt = {{(`MIPS_WORD_WIDTH-`MIPS_IMM_WIDTH){instr[15]}}, instr[15:0]};
    assign aluB   = aluSrcImm ? immExt : rdDataB;

    alu alu_inst (
        .a       (rdDataA),
        .b       (aluB),
        .command (aluCommand),
        .result  (aluResult),
        .zero    (aluZero)
    );

    // load port owns the dmem write side while reset is high
    assign dmemWrEn   = reset ? (loadEn && loadSel) : ctrlWrEnDm;
    assign dmemWrAddr = reset ? loadAddr[dmemAddrWidth-1:0] : aluResult[dmemAddrWidth+1:2];
    assign dmemWrData = reset ? loadData : rdDataB;

    wordMemory #(.depth(`MIPS_DMEM_DEPTH)) dmem (
        .clk    (clk),
        .rdAddr (aluResult[dmemAddrWidth+1:2]),
        .rdData (dmemRdData),
        .wrEn   (dmemWrEn),
        .wrAddr (dmemWrAddr),
        .wrData (dmemWrData)
    );

    // next pc, jump first, then taken bne, else sequential
    assign pcPlus4      = pc + mipsPkg::wordT'(4);
    assign jumpTarget   = {pcPlus4[31:28], instr[25:0], 2'b00};
    assign branchTarget = pcPlus4 + {immExt[29:0], 2'b00};
    assign nextPc       = jump ? jumpTarget :
                          (branch && !aluZero) ? branchTarget : pcPlus4;

    // write-back address
    always_comb begin
        case (regDst)
            mipsPkg::regDstRd: regWrAddr = instr[15:11];
            mipsPkg::regDstRa: regWrAddr = 5'(`MIPS_RA_INDEX);
            default:           regWrAddr = instr[20:16];
        endcase
    end

    // write-back data
    always_comb begin
        case (regDataSrc)
            mipsPkg::srcDataMem: regWrData = dmemRdData;
            mipsPkg::srcPcPlus4: regWrData = pcPlus4;
            default:             regWrData = aluResult;
        endcase
    end

    // no core writes while reset holds
    assign regWrEn   = ctrlWrEnReg && !reset;
    assign memWrEn   = ctrlWrEnDm && !reset;
    assign memWrAddr = aluResult;
    assign memWrData = rdDataB;

    // jump and branch targets both carry two low zero bits
    pcAligned: assert property (
        @(posedge clk) disable iff (reset) pc[1:0] == 2'b00
    ) else $error("singleCycleCpu: pc 0x%08h not word aligned", pc);

endmodule

`default_nettype wire

/* tb/cpuTestbench.sv */
`timescale 1ns/10ps
`default_nettype none

`include "mipsDefs.svh"

module cpuTestbench;

    logic        clk;
    logic        reset;
    logic        loadEn;
    logic        loadSel;
    logic [7:0]  loadAddr;
    logic [31:0] loadData;
    logic [31:0] pc;
    logic        regWrEn;
    logic [4:0]  regWrAddr;
    logic [31:0] regWrData;
    logic        memWrEn;
    logic [31:0] memWrAddr;
    logic [31:0] memWrData;

    // reference model state
    logic [31:0] progMem [`MIPS_IMEM_DEPTH];
    logic [31:0] modelMem [`MIPS_DMEM_DEPTH];
    logic [31:0] modelRegs [`MIPS_REG_COUNT];
    logic [31:0] modelPc;
    logic [31:0] rngState;

    singleCycleCpu singleCycleCpu_inst (
        .clk       (clk),
        .reset     (reset),
        .loadEn    (loadEn),
        .loadSel   (loadSel),
        .loadAddr  (loadAddr),
        .loadData  (loadData),
        .pc        (pc),
        .regWrEn   (regWrEn),
        .regWrAddr (regWrAddr),
        .regWrData (regWrData),
        .memWrEn   (memWrEn),
        .memWrAddr (memWrAddr),
        .memWrData (memWrData)
    );

    // 40 ns period
    always #20 clk = ~clk;

    task automatic stopOnFailure();
        $display("Simulation finished: FAIL");
        $fatal(1, "stopping at first error");
    endtask

    task automatic checkValue(input string label, input logic [31:0] expected,
                              input logic [31:0] actual);
        if (expected !== actual) begin
            $display("CHECK FAILED %s: expected 0x%08h, actual 0x%08h", label, expected, actual);
            stopOnFailure();
        end
    endtask

    // xorshift32
    function automatic logic [31:0] nextRandom();
        rngState = rngState ^ (rngState << 13);
        rngState = rngState ^ (rngState >> 17);
        rngState = rngState ^ (rngState << 5);
        return rngState;
    endfunction

    // instruction encoders
    function automatic logic [31:0] encI(input logic [5:0] op, input logic [4:0] rs,
                                         input logic [4:0] rt, input int imm);
        return {op, rs, rt, imm[15:0]};
    endfunction

    function automatic logic [31:0] encR(input logic [4:0] rs, input logic [4:0] rt,
                                         input logic [4:0] rd, input logic [2:0] funct);
        return {mipsPkg::opRType, rs, rt, rd, 5'd0, 3'd0, funct};
    endfunction

    function automatic logic [31:0] encJ(input logic [5:0] op, input int wordIndex);
        return {op, wordIndex[25:0]};
    endfunction

    // expected alu result, straight from the operation table
    function automatic logic [31:0] aluRef(input logic [2:0] cmd, input logic [31:0] a,
                                           input logic [31:0] b);
        case (cmd)
            mipsPkg::aluAdd:  return a + b;
            mipsPkg::aluSub:  return a - b;
            mipsPkg::aluXor:  return a ^ b;
            mipsPkg::aluSlt:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            mipsPkg::aluAnd:  return a & b;
            mipsPkg::aluNand: return ~(a & b);
            mipsPkg::aluNor:  return ~(a | b);
            default:          return a | b;
        endcase
    endfunction

    // one cycle under reset, core must stay quiet
    task automatic resetCycle();
        #10;
        checkValue("reset pc", 32'd0, pc);
        checkValue("reset regWrEn", 32'd0, 32'(regWrEn));
        checkValue("reset memWrEn", 32'd0, 32'(memWrEn));
        @(negedge clk);
    endtask

    // hold reset, fill imem and dmem, then release
    task automatic loadProgram(input int count);
        @(negedge clk);
        reset  = 1'b1;
        loadEn = 1'b0;
        @(negedge clk);
        for (int i = 0; i < count; i++) begin
            loadEn   = 1'b1;
            loadSel  = 1'b0;
            loadAddr = 8'(i);
            loadData = progMem[i];
            resetCycle();
        end
        for (int i = 0; i < `MIPS_DMEM_DEPTH; i++) begin
            loadEn   = 1'b1;
            loadSel  = 1'b1;
            loadAddr = 8'(i);
            loadData = modelMem[i];
            resetCycle();
        end
        loadEn = 1'b0;
        // two more reset cycles once loaded
        resetCycle();
        resetCycle();
        reset = 1'b0;
        for (int i = 0; i < `MIPS_REG_COUNT; i++) begin
            modelRegs[i] = '0;
        end
        modelPc = '0;
    endtask

    // execute one instruction in the model and compare the trace
    task automatic stepCheck(input string name);
        logic [31:0] instr;
        logic [5:0]  op;
        logic [31:0] imm;
        logic [31:0] pcPlus4;
        logic [31:0] nextPc;
        logic [31:0] addr;
        logic [31:0] regData;
        logic [31:0] memData;
        logic [4:0]  regAddr;
        logic        expReg;
        logic        expMem;
        instr   = progMem[modelPc[9:2]];
        op      = instr[31:26];
        imm     = {{16{instr[15]}}, instr[15:0]};
        pcPlus4 = modelPc + 32'd4;
        nextPc  = pcPlus4;
        addr    = modelRegs[instr[25:21]] + imm;
        expReg  = 1'b0;
        expMem  = 1'b0;
        regAddr = '0;
        regData = '0;
        memData = modelRegs[instr[20:16]];
        case (op)
            mipsPkg::opLw: begin
                expReg  = 1'b1;
                regAddr = instr[20:16];
                regData = modelMem[addr[9:2]];
            end
            mipsPkg::opSw: expMem = 1'b1;
            mipsPkg::opJ: nextPc = {pcPlus4[31:28], instr[25:0], 2'b00};
            mipsPkg::opJal: begin
                nextPc  = {pcPlus4[31:28], instr[25:0], 2'b00};
                expReg  = 1'b1;
                regAddr = 5'd31;
                regData = pcPlus4;
            end
            mipsPkg::opBne: begin
                if (modelRegs[instr[25:21]] != modelRegs[instr[20:16]]) begin
                    nextPc = pcPlus4 + (imm << 2);
                end
            end
            mipsPkg::opRType: begin
                expReg  = 1'b1;
                regAddr = instr[15:11];
                regData = aluRef(instr[2:0], modelRegs[instr[25:21]], modelRegs[instr[20:16]]);
            end
            default: ;
        endcase
        // mid-cycle, outputs settled
        #10;
        checkValue({name, " pc"}, modelPc, pc);
        checkValue({name, " regWrEn"}, 32'(expReg), 32'(regWrEn));
        checkValue({name, " memWrEn"}, 32'(expMem), 32'(memWrEn));
        if (expReg) begin
            checkValue({name, " regWrAddr"}, 32'(regAddr), 32'(regWrAddr));
            checkValue({name, " regWrData"}, regData, regWrData);
            if (regAddr != 5'd0) begin
                modelRegs[regAddr] = regData;
            end
        end
        if (expMem) begin
            checkValue({name, " memWrAddr"}, addr, memWrAddr);
            checkValue({name, " memWrData"}, memData, memWrData);
            modelMem[addr[9:2]] = memData;
        end
        modelPc = nextPc;
        @(negedge clk);
    endtask

    // step until the end marker, bounded
    task automatic runProgram(input string name, input int endPc);
        int cycles;
        cycles = 0;
        while (pc !== 32'(endPc)) begin
            stepCheck(name);
            cycles++;
            if (cycles > 64) begin
                $display("%s: pc never reached end marker 0x%08h", name, endPc);
                stopOnFailure();
            end
        end
        checkValue({name, " model pc at end"}, 32'(endPc), modelPc);
    endtask

    // fresh random data and an all-zero program
    task automatic prepareTest();
        for (int i = 0; i < `MIPS_IMEM_DEPTH; i++) begin
            progMem[i] = '0;
        end
        for (int i = 0; i < `MIPS_DMEM_DEPTH; i++) begin
            modelMem[i] = nextRandom();
        end
    endtask

    task automatic testLoadStore();
        prepareTest();
        // base register value for the negative offset
        modelMem[16] = 32'h80;
        progMem[0] = encI(mipsPkg::opLw, 5'd0, 5'd1, 20);
        progMem[1] = encI(mipsPkg::opLw, 5'd0, 5'd2, 36);
        progMem[2] = encI(mipsPkg::opLw, 5'd0, 5'd3, 64);
        progMem[3] = encI(mipsPkg::opSw, 5'd3, 5'd1, -8);
        progMem[4] = encI(mipsPkg::opSw, 5'd0, 5'd2, 200);
        // read back what was just stored
        progMem[5] = encI(mipsPkg::opLw, 5'd3, 5'd4, -8);
        loadProgram(6);
        runProgram("loadStore", 24);
    endtask

    task automatic testAluOps();
        prepareTest();
        // r1 negative, r2 positive for slt both ways
        modelMem[0] = modelMem[0] | 32'h8000_0000;
        modelMem[1] = modelMem[1] & 32'h7fff_ffff;
        progMem[0] = encI(mipsPkg::opLw, 5'd0, 5'd1, 0);
        progMem[1] = encI(mipsPkg::opLw, 5'd0, 5'd2, 4);
        for (int f = 0; f < 8; f++) begin
            progMem[2 + f] = encR(5'd1, 5'd2, 5'(8 + f), 3'(f));
        end
        progMem[10] = encR(5'd2, 5'd1, 5'd20, mipsPkg::aluSlt);
        loadProgram(11);
        runProgram("aluOps", 44);
    endtask

    task automatic testBranch();
        prepareTest();
        modelMem[1] = ~modelMem[0];
        progMem[0] = encI(mipsPkg::opLw, 5'd0, 5'd1, 0);
        progMem[1] = encI(mipsPkg::opLw, 5'd0, 5'd2, 4);
        progMem[2] = encI(mipsPkg::opLw, 5'd0, 5'd3, 0);
        // equal, falls through
        progMem[3] = encI(mipsPkg::opBne, 5'd1, 5'd3, 5);
        // forward to word 9, then back to word 7
        progMem[4] = encI(mipsPkg::opBne, 5'd1, 5'd2, 4);
        progMem[9] = encI(mipsPkg::opBne, 5'd1, 5'd2, -3);
        progMem[7] = encJ(mipsPkg::opJ, 11);
        loadProgram(12);
        runProgram("branch", 44);
    endtask

    task automatic testJumps();
        prepareTest();
        progMem[0] = encJ(mipsPkg::opJ, 3);
        progMem[3] = encJ(mipsPkg::opJal, 6);
        // link value seen through a store
        progMem[6] = encI(mipsPkg::opSw, 5'd0, 5'd31, 0);
        loadProgram(7);
        runProgram("jumps", 28);
    endtask

    task automatic testZeroAndNoOp();
        logic [31:0] operandBits;
        prepareTest();
        modelMem[0] = modelMem[0] | 32'h1;
        progMem[0] = encI(mipsPkg::opLw, 5'd0, 5'd1, 0);
        progMem[1] = encR(5'd1, 5'd1, 5'd0, mipsPkg::aluOr);
        progMem[2] = encI(mipsPkg::opSw, 5'd0, 5'd0, 8);
        // unused opcodes, random operand bits
        operandBits = nextRandom();
        progMem[3] = {6'h3f, operandBits[25:0]};
        operandBits = nextRandom();
        progMem[4] = {6'h00, operandBits[25:0]};
        loadProgram(5);
        runProgram("zeroAndNoOp", 20);
    endtask

    task automatic testReset();
        prepareTest();
        modelMem[0] = modelMem[0] | 32'h1;
        progMem[0] = encI(mipsPkg::opLw, 5'd0, 5'd1, 0);
        loadProgram(1);
        runProgram("resetFirst", 4);
        // r1 must be cleared by the second reset
        progMem[0] = encI(mipsPkg::opSw, 5'd0, 5'd1, 4);
        loadProgram(1);
        runProgram("resetSecond", 4);
    endtask

    initial begin
        clk      = 1'b0;
        reset    = 1'b1;
        loadEn   = 1'b0;
        loadSel  = 1'b0;
        loadAddr = '0;
        loadData = '0;
        rngState = 32'hd5f6_6b48;
        testLoadStore();
        testAluOps();
        testBranch();
        testJumps();
        testZeroAndNoOp();
        testReset();
        $display("Simulation finished: PASS");
        $finish;
    end

    // overall limit
    initial begin
        #1_000_000;
        $display("simulation ran past its time limit");
        stopOnFailure();
    end

endmodule

`default_nettype wire

/* singleCycleCpu.f */
+incdir+source
source/mipsPkg.sv
source/controlUnitLUT.sv
source/alu.sv
source/registerFile.sv
source/wordMemory.sv
source/singleCycleCpu.sv
tb/cpuTestbench.sv

/* runSim.sh */
#!/bin/sh
# Build and run the single-cycle CPU testbench with Verilator.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    -f singleCycleCpu.f \
    --top-module cpuTestbench \
    -o cpuSim

./obj_dir/cpuSim 2>&1 | tee sim.log

if grep -q "Simulation finished: FAIL" sim.log; then
    echo "runSim: failure reported"
    exit 1
fi

if ! grep -q "Simulation finished: PASS" sim.log; then
    echo "runSim: no pass message found"
    exit 1
fi

echo "runSim: passed"
